//--- corr_accum.sv
`include "corr_settings.svh"

module corr_accum (
   input  logic                clk_x,
   input  logic                sw_d,
   input  corr_pkg::pair_op_t  op_i,
   output corr_pkg::vis_res_t  res_o
);

   localparam int ACC_W = `ACCUM_BITS;

   corr_pkg::vis_t        acc_q [`NUM_PAIRS];  // One {sin, cos} per slot
   corr_pkg::vis_t        base;
   corr_pkg::vis_t        acc_d;
   logic                  cos_hit;
   logic                  sin_hit;
   logic                  res_vld_q;
   logic [`SLOT_BITS-1:0] res_slot_q;
   corr_pkg::vis_t        res_vis_q;

   // --------------------------------------------------
   // Agreement test and next count
   // --------------------------------------------------
   always_comb begin
      cos_hit   = op_i.re_a == op_i.re_b;   // Real against real
      sin_hit   = op_i.im_a == op_i.re_b;   // Quadrature against real
      // First sample of a block starts from zero
      base      = op_i.first ? '0 : acc_q[op_i.slot];
      acc_d.cos = base.cos + ACC_W'(cos_hit);
      acc_d.sin = base.sin + ACC_W'(sin_hit);
   end

   // Time-multiplexed count store
   always_ff @(posedge clk_x) begin
      if (op_i.vld) begin
         acc_q[op_i.slot] <= acc_d;
      end
   end

   // --------------------------------------------------
   // Finished visibilities
   // --------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         res_vld_q <= 1'b0;
      end else begin
         res_vld_q <= op_i.vld && op_i.last;  // Only on the closing sample
      end
   end

   // Payload of the result
   always_ff @(posedge clk_x) begin
      if (op_i.vld && op_i.last) begin
         res_slot_q <= op_i.slot;
         res_vis_q  <= acc_d;   // Includes the last sample
      end
   end

   assign res_o = '{vld: res_vld_q, slot: res_slot_q, vis: res_vis_q};

endmodule

//--- corr_pkg.sv
`include "corr_settings.svh"

package corr_pkg;

   // --------------------------------------------------
   // Decode to execute
   // --------------------------------------------------
   typedef struct packed {
      logic                  vld;
      logic [`SLOT_BITS-1:0] slot;   // Pair index
      logic                  re_a;   // Real part, antenna a
      logic                  re_b;   // Real part, antenna b
      logic                  im_a;   // Previous bit of antenna a
      logic                  first;  // Restart the counts
      logic                  last;   // Block ends with this sample
   } pair_op_t;

   // Agreement counts for one pair
   typedef struct packed {
      logic [`ACCUM_BITS-1:0] sin;
      logic [`ACCUM_BITS-1:0] cos;
   } vis_t;

   // Execute to buffer, one finished pair
   typedef struct packed {
      logic                  vld;
      logic [`SLOT_BITS-1:0] slot;
      vis_t                  vis;
   } vis_res_t;

   // Sample capture FSM
   typedef enum logic {
      DEC_IDLE,    // Waiting for enable
      DEC_ISSUE    // Walking the pairs
   } decode_state_e;

endpackage

//--- corr_settings.svh
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// --------------------------------------------------
// Array geometry
// --------------------------------------------------
`define NUM_ANTENNA 4    // One-bit antenna inputs
`define NUM_PAIRS   6    // Pairs a < b, one per clock
`define TMUX_RATE   6    // Clocks per sample, equal to the pair count

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define ACCUM_BITS  9    // Each of sin and cos
`define COUNT_BITS  8    // Block size, samples minus one
`define SLOT_BITS   3    // Pair index

// Readback flow control
`define RD_CREDITS  4    // Most credits the sender may hold

`endif

//--- corr_tb.sv
`include "corr_settings.svh"

module corr_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CR_NONE   = 0;   // Credit modes
   localparam int CR_SPARSE = 1;
   localparam int CR_FREE   = 2;
   localparam int TOTAL_SAMPLES = 88;   // Summed over all tests below
   localparam int NUM_TESTS     = 5;
   localparam int SETTLE        = 40;   // Pipeline drain and idle per test
   localparam int CYCLE_LIMIT   =
      2 * (TOTAL_SAMPLES * `TMUX_RATE + NUM_TESTS * SETTLE + 3);

   logic                    clk_x;
   logic                    sw_d;
   logic                    enable_i;
   logic [`COUNT_BITS-1:0]  blocksize_i;
   logic [`NUM_ANTENNA-1:0] antenna_i;
   logic                    rd_credit_i;
   logic                    rd_vld_o;
   rdbk_pkg::vis_word_t     rd_word_o;
   logic                    overflow_o;

   // Pair table, a < b in order
   int pair_a [`NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
   int pair_b [`NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

   // Reference model state
   logic [`ACCUM_BITS-1:0]  exp_sin [256][`NUM_PAIRS];
   logic [`ACCUM_BITS-1:0]  exp_cos [256][`NUM_PAIRS];
   bit                      done_blk [256];
   logic [`ACCUM_BITS-1:0]  m_sin [`NUM_PAIRS];
   logic [`ACCUM_BITS-1:0]  m_cos [`NUM_PAIRS];
   logic [`NUM_ANTENNA-1:0] prev_s;      // im source, cleared per run
   logic [`COUNT_BITS-1:0]  cur_bs;
   int                      blk_pos;
   int                      blk_len;
   int                      model_seq;   // Completed blocks, dropped ones too
   bit                      running;

   // Bookkeeping
   logic [15:0]             stim_st;
   logic [15:0]             cred_st;
   int                      credit_mode;
   int                      given;
   int                      words_rx;
   int                      exp_words;
   int                      val_errors;
   int                      other_errors;
   int                      cycles;
   int                      exp_slot;
   logic [7:0]              cur_seq;
   bit                      have_seq;
   logic                    give;
   logic                    b0;
   logic                    b1;

   corr_top dut (
      .clk_x       (clk_x),
      .sw_d        (sw_d),
      .enable_i    (enable_i),
      .blocksize_i (blocksize_i),
      .antenna_i   (antenna_i),
      .rd_credit_i (rd_credit_i),
      .rd_vld_o    (rd_vld_o),
      .rd_word_o   (rd_word_o),
      .overflow_o  (overflow_o)
   );

   initial clk_x = 1'b0;
   always #20 clk_x = ~clk_x;   // 40 ns period

   // --------------------------------------------------
   // Random bits, 16-bit Fibonacci LFSR
   // --------------------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
   endfunction

   function automatic logic stim_bit();
      stim_st  = lfsr_next(stim_st);
      stim_bit = stim_st[0];
   endfunction

   function automatic logic credit_bit();
      cred_st    = lfsr_next(cred_st);
      credit_bit = cred_st[0];
   endfunction

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
         val_errors++;
      end
   endtask

   task automatic flag_error(input string msg);
      $display("Error: %s", msg);
      other_errors++;
   endtask

   // Drive one sample and fold it into the model
   task automatic put_sample();
      logic [`NUM_ANTENNA-1:0] s;
      bit                      starts;
      for (int i = 0; i < `NUM_ANTENNA; i++) begin
         s[i] = stim_bit();
      end
      starts = blk_pos == 0;
      if (starts) begin
         blk_len = int'(cur_bs) + 1;
         for (int p = 0; p < `NUM_PAIRS; p++) begin
            m_sin[p] = '0;
            m_cos[p] = '0;
         end
      end
      for (int p = 0; p < `NUM_PAIRS; p++) begin
         if (s[pair_a[p]] == s[pair_b[p]]) m_cos[p] = m_cos[p] + 1'b1;
         if (prev_s[pair_a[p]] == s[pair_b[p]]) m_sin[p] = m_sin[p] + 1'b1;
      end
      prev_s = s;
      blk_pos++;
      if (blk_pos == blk_len) begin   // Block closes with this sample
         for (int p = 0; p < `NUM_PAIRS; p++) begin
            exp_sin[model_seq][p] = m_sin[p];
            exp_cos[model_seq][p] = m_cos[p];
         end
         done_blk[model_seq] = 1'b1;
         model_seq++;
         blk_pos = 0;
      end
      if (!running) begin
         @(posedge clk_x);
         enable_i <= 1'b1;
      end
      antenna_i <= s;
      if (starts) blocksize_i <= cur_bs;   // Latched at the block's first capture
      if (running) begin
         repeat (`TMUX_RATE) @(posedge clk_x);
      end else begin
         @(posedge clk_x);                  // First capture right after enable
      end
      running = 1'b1;
   endtask

   task automatic put_blocks(input int n, input logic [7:0] bs);
      cur_bs = bs;
      for (int i = 0; i < n * (int'(bs) + 1); i++) begin
         put_sample();
      end
   endtask

   // Let the last sample's ops finish, then drop enable
   task automatic finish_run();
      repeat (`TMUX_RATE + 1) @(posedge clk_x);
      enable_i <= 1'b0;
      running  = 1'b0;
      prev_s   = '0;
   endtask

   // Drop enable in the middle of a block
   task automatic abandon_run();
      repeat (2) @(posedge clk_x);
      enable_i <= 1'b0;
      running  = 1'b0;
      prev_s   = '0;
      blk_pos  = 0;
      @(posedge clk_x);
   endtask

   task automatic wait_words(input logic ovf_exp);
      while (words_rx < exp_words) @(posedge clk_x);
      repeat (10) @(posedge clk_x);   // Catch any extra word
      check_val("word count", 32'(words_rx), 32'(exp_words));
      check_val("overflow_o", 32'(overflow_o), 32'(ovf_exp));
   endtask

   // --------------------------------------------------
   // Credit driver
   // --------------------------------------------------
   always @(posedge clk_x) begin
      if (sw_d) begin
         rd_credit_i <= 1'b0;
      end else begin
         give = 1'b0;
         if (credit_mode == CR_FREE) begin
            give = (given - words_rx) < `RD_CREDITS;
         end else if (credit_mode == CR_SPARSE) begin
            b0   = credit_bit();
            b1   = credit_bit();
            give = b0 && b1 && (given - words_rx) < `RD_CREDITS;   // About one in four
         end
         rd_credit_i <= give;
         if (give) given++;
      end
   end

   // --------------------------------------------------
   // Word monitor
   // --------------------------------------------------
   always @(posedge clk_x) begin
      if (!sw_d && rd_vld_o) begin
         words_rx++;
         if (words_rx > given) flag_error("more words received than credits given");
         if (int'(rd_word_o.slot) != exp_slot) flag_error("word out of slot order");
         if (exp_slot == 0) begin
            if (!overflow_o) begin
               // Nothing dropped yet, blocks follow on from zero
               check_val("block_seq", 32'(rd_word_o.block_seq),
                         have_seq ? 32'(8'(cur_seq + 1)) : 32'd0);
            end else if (have_seq && rd_word_o.block_seq <= cur_seq) begin
               flag_error("block sequence number did not advance");
            end
            cur_seq  = rd_word_o.block_seq;
            have_seq = 1'b1;
         end else begin
            check_val("block_seq", 32'(rd_word_o.block_seq), 32'(cur_seq));
         end
         if (!done_blk[rd_word_o.block_seq]) begin
            flag_error("word for a block the model has not finished");
         end else begin
            check_val("vis.sin", 32'(rd_word_o.vis.sin),
                      32'(exp_sin[rd_word_o.block_seq][exp_slot]));
            check_val("vis.cos", 32'(rd_word_o.vis.cos),
                      32'(exp_cos[rd_word_o.block_seq][exp_slot]));
         end
         check_val("last", 32'(rd_word_o.last), 32'(exp_slot == `NUM_PAIRS - 1));
         exp_slot = (exp_slot == `NUM_PAIRS - 1) ? 0 : exp_slot + 1;
      end
   end

   // Watchdog
   always @(posedge clk_x) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the expected words never arrived", cycles);
         $display("Value errors %0d, other errors %0d", val_errors, other_errors + 1);
         $display("Done: errors found");
         $finish;
      end
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      sw_d        = 1'b1;
      enable_i    = 1'b0;
      blocksize_i = '0;
      antenna_i   = '0;
      rd_credit_i = 1'b0;
      stim_st     = 16'd45901;
      cred_st     = 16'd45901;
      credit_mode = CR_FREE;
      prev_s      = '0;
      cur_bs      = '0;
      blk_pos     = 0;
      blk_len     = 1;
      model_seq   = 0;
      running     = 1'b0;
      given       = 0;
      words_rx    = 0;
      exp_words   = 0;
      val_errors  = 0;
      other_errors = 0;
      cycles      = 0;
      exp_slot    = 0;
      cur_seq     = '0;
      have_seq    = 1'b0;
      repeat (3) @(posedge clk_x);
      sw_d <= 1'b0;

      // Free credits, three blocks back to back
      put_blocks(3, 8'd3);
      exp_words += 3 * `NUM_PAIRS;
      finish_run();
      wait_words(1'b0);

      // Abandoned block, then a fresh one
      cur_bs = 8'd5;
      put_sample();
      put_sample();
      abandon_run();
      put_blocks(1, 8'd5);
      exp_words += `NUM_PAIRS;
      finish_run();
      wait_words(1'b0);

      // Sparse credits
      credit_mode = CR_SPARSE;
      put_blocks(2, 8'd20);
      exp_words += 2 * `NUM_PAIRS;
      finish_run();
      wait_words(1'b0);

      // No credits over three completions, first kept, next two dropped
      credit_mode = CR_NONE;
      put_blocks(3, 8'd3);
      put_sample();
      put_sample();
      credit_mode = CR_FREE;   // Dropped blocks are complete by now
      put_sample();
      put_sample();
      exp_words += 2 * `NUM_PAIRS;
      finish_run();
      wait_words(1'b1);

      // Size change between blocks
      put_blocks(1, 8'd2);
      put_blocks(1, 8'd6);
      exp_words += 2 * `NUM_PAIRS;
      finish_run();
      wait_words(1'b1);

      $display("Value errors %0d, other errors %0d, words %0d",
               val_errors, other_errors, words_rx);
      if (val_errors == 0 && other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- corr_top.sv
`include "corr_settings.svh"

module corr_top (
   input  logic                    clk_x,         // Six times the sample rate
   input  logic                    sw_d,
   input  logic                    enable_i,
   input  logic [`COUNT_BITS-1:0]  blocksize_i,
   input  logic [`NUM_ANTENNA-1:0] antenna_i,
   input  logic                    rd_credit_i,
   output logic                    rd_vld_o,
   output rdbk_pkg::vis_word_t     rd_word_o,
   output logic                    overflow_o
);

   corr_pkg::pair_op_t op;    // Decode to execute
   corr_pkg::vis_res_t res;   // Execute to buffer

   // --------------------------------------------------
   // Decode
   // --------------------------------------------------
   sample_decode u_decode (
      .clk_x       (clk_x),
      .sw_d        (sw_d),
      .enable_i    (enable_i),
      .blocksize_i (blocksize_i),
      .antenna_i   (antenna_i),
      .op_o        (op)
   );

   // --------------------------------------------------
   // Execute
   // --------------------------------------------------
   corr_accum u_accum (
      .clk_x (clk_x),
      .sw_d  (sw_d),
      .op_i  (op),
      .res_o (res)
   );

   // --------------------------------------------------
   // Result, banks and readback
   // --------------------------------------------------
   vis_readout u_readout (
      .clk_x       (clk_x),
      .sw_d        (sw_d),
      .res_i       (res),
      .rd_credit_i (rd_credit_i),
      .rd_vld_o    (rd_vld_o),
      .rd_word_o   (rd_word_o),
      .overflow_o  (overflow_o)
   );

endmodule

//--- rdbk_pkg.sv
`include "corr_settings.svh"

package rdbk_pkg;

   // Block number, wraps at 256
   typedef logic [7:0] block_seq_t;

   // --------------------------------------------------
   // One word to the consumer
   // --------------------------------------------------
   typedef struct packed {
      block_seq_t            block_seq;  // Block it came from
      logic [`SLOT_BITS-1:0] slot;       // Pair index
      logic                  last;       // Final pair of the block
      corr_pkg::vis_t        vis;        // {sin, cos}
   } vis_word_t;

   // Sender FSM
   typedef enum logic {
      RO_IDLE,     // Read bank empty
      RO_SEND      // Draining the read bank
   } readout_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f src.f --top-module corr_tb -o corr_sim

out=$(./obj_dir/corr_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
   exit 0
else
   exit 1
fi

//--- sample_decode.sv
`include "corr_settings.svh"

module sample_decode (
   input  logic                    clk_x,
   input  logic                    sw_d,
   input  logic                    enable_i,
   input  logic [`COUNT_BITS-1:0]  blocksize_i,  // Samples per block minus one
   input  logic [`NUM_ANTENNA-1:0] antenna_i,
   output corr_pkg::pair_op_t      op_o
);

   localparam int AX_BITS = $clog2(`NUM_ANTENNA);
   localparam int SLOT_W  = `SLOT_BITS;
   localparam logic [SLOT_W-1:0] LAST_PHASE = SLOT_W'(`TMUX_RATE - 1);

   corr_pkg::decode_state_e state_q;
   logic [SLOT_W-1:0]       phase_q;    // Pair being issued
   logic [`NUM_ANTENNA-1:0] re_q;       // Current sample
   logic [`NUM_ANTENNA-1:0] im_q;       // Previous sample, fake Hilbert
   logic                    first_q;    // Flags of the held sample
   logic                    last_q;
   logic [`COUNT_BITS-1:0]  samp_q;     // Sample index within block
   logic [`COUNT_BITS-1:0]  size_q;     // Latched block size
   logic [`COUNT_BITS-1:0]  size_now;
   logic                    capture;
   logic                    end_blk;
   logic [AX_BITS-1:0]      ax_a;
   logic [AX_BITS-1:0]      ax_b;
   corr_pkg::pair_op_t      op_d;

   // --------------------------------------------------
   // Pair table, slot to antennas {a, b}
   // --------------------------------------------------
   function automatic logic [2*AX_BITS-1:0] pair_of(input logic [SLOT_W-1:0] slot);
      case (slot)
         0:       pair_of = {AX_BITS'(0), AX_BITS'(1)};
         1:       pair_of = {AX_BITS'(0), AX_BITS'(2)};
         2:       pair_of = {AX_BITS'(0), AX_BITS'(3)};
         3:       pair_of = {AX_BITS'(1), AX_BITS'(2)};
         4:       pair_of = {AX_BITS'(1), AX_BITS'(3)};
         default: pair_of = {AX_BITS'(2), AX_BITS'(3)};
      endcase
   endfunction

   // First enabled edge, then every sixth clock
   assign capture  = enable_i &&
                     (state_q == corr_pkg::DEC_IDLE || phase_q == LAST_PHASE);
   assign size_now = (samp_q == '0) ? blocksize_i : size_q;  // New block takes the input
   assign end_blk  = samp_q == size_now;

   // Op for the current phase
   always_comb begin
      {ax_a, ax_b} = pair_of(phase_q);
      op_d         = '0;
      op_d.vld     = state_q == corr_pkg::DEC_ISSUE;
      op_d.slot    = phase_q;
      op_d.re_a    = re_q[ax_a];
      op_d.re_b    = re_q[ax_b];
      op_d.im_a    = im_q[ax_a];   // a's previous bit
      op_d.first   = first_q;
      op_d.last    = last_q;
   end

   // --------------------------------------------------
   // Capture and issue
   // --------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         state_q <= corr_pkg::DEC_IDLE;
         phase_q <= '0;
         re_q    <= '0;
         im_q    <= '0;
         first_q <= 1'b0;
         last_q  <= 1'b0;
         samp_q  <= '0;
         size_q  <= '0;
         op_o    <= '0;
      end else if (!enable_i) begin
         // Abandon any partial block
         state_q <= corr_pkg::DEC_IDLE;
         phase_q <= '0;
         re_q    <= '0;     // So the next first sample sees zero im
         im_q    <= '0;
         samp_q  <= '0;
         op_o    <= '0;
      end else begin
         state_q <= corr_pkg::DEC_ISSUE;
         op_o    <= op_d;
         if (state_q == corr_pkg::DEC_ISSUE) begin
            phase_q <= (phase_q == LAST_PHASE) ? '0 : phase_q + 1'b1;
         end
         if (capture) begin
            re_q    <= antenna_i;
            im_q    <= re_q;              // Previous sample becomes im
            first_q <= samp_q == '0;
            last_q  <= end_blk;
            samp_q  <= end_blk ? '0 : samp_q + 1'b1;
            if (samp_q == '0) begin
               size_q <= blocksize_i;     // Held for the whole block
            end
         end
      end
   end

endmodule

//--- src.f
+incdir+.
corr_pkg.sv
rdbk_pkg.sv
sample_decode.sv
corr_accum.sv
vis_readout.sv
corr_top.sv
corr_tb.sv

//--- vis_readout.sv
`include "corr_settings.svh"

module vis_readout (
   input  logic                clk_x,
   input  logic                sw_d,
   input  corr_pkg::vis_res_t  res_i,
   input  logic                rd_credit_i,   // One pulse per credit
   output logic                rd_vld_o,
   output rdbk_pkg::vis_word_t rd_word_o,
   output logic                overflow_o     // Sticky, a block was dropped
);

   localparam int CRED_W = $clog2(`RD_CREDITS + 1);
   localparam int SLOT_W = `SLOT_BITS;
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`NUM_PAIRS - 1);

   corr_pkg::vis_t           bank_q [2][`NUM_PAIRS];  // Fill and read banks
   logic                     fill_q;      // Bank being filled
   logic                     rd_full_q;   // Read bank holds an unsent block
   rdbk_pkg::block_seq_t     seq_q;       // Blocks completed so far
   rdbk_pkg::block_seq_t     rd_seq_q;    // Number of the block in the read bank
   logic [CRED_W-1:0]        cred_q;
   rdbk_pkg::readout_state_e state_q;
   logic [SLOT_W-1:0]        rd_slot_q;   // Next word to send
   logic                     blk_done;
   logic                     send;
   logic                     free_now;
   logic                     swap;
   rdbk_pkg::vis_word_t      word_d;

   // --------------------------------------------------
   // Bank control
   // --------------------------------------------------
   assign blk_done = res_i.vld && res_i.slot == LAST_SLOT;
   assign send     = state_q == rdbk_pkg::RO_SEND && cred_q != '0;
   assign free_now = send && rd_slot_q == LAST_SLOT;      // Read bank empties now
   assign swap     = blk_done && (!rd_full_q || free_now);

   // Results land in the fill bank
   always_ff @(posedge clk_x) begin
      if (res_i.vld) begin
         bank_q[fill_q][res_i.slot] <= res_i.vis;
      end
   end

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         fill_q     <= 1'b0;
         rd_full_q  <= 1'b0;
         seq_q      <= '0;
         rd_seq_q   <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (blk_done) begin
            seq_q <= seq_q + 1'b1;   // Dropped blocks count too
         end
         if (swap) begin
            fill_q    <= !fill_q;
            rd_full_q <= 1'b1;
            rd_seq_q  <= seq_q;
         end else begin
            if (free_now) begin
               rd_full_q <= 1'b0;
            end
            if (blk_done) begin
               overflow_o <= 1'b1;   // Read bank still busy, block lost
            end
         end
      end
   end

   // --------------------------------------------------
   // Credits
   // --------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         cred_q <= '0;
      end else begin
         case ({rd_credit_i, send})
            2'b10:   cred_q <= cred_q + 1'b1;
            2'b01:   cred_q <= cred_q - 1'b1;
            default: cred_q <= cred_q;   // None, or one in and one out
         endcase
      end
   end

   // --------------------------------------------------
   // Sender
   // --------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         state_q   <= rdbk_pkg::RO_IDLE;
         rd_slot_q <= '0;
         rd_vld_o  <= 1'b0;
      end else begin
         rd_vld_o <= send;
         case (state_q)
            rdbk_pkg::RO_IDLE: begin
               if (rd_full_q) begin
                  state_q   <= rdbk_pkg::RO_SEND;
                  rd_slot_q <= '0;
               end
            end
            default: begin
               if (send) begin
                  rd_slot_q <= rd_slot_q + 1'b1;
                  if (rd_slot_q == LAST_SLOT) begin
                     state_q <= rdbk_pkg::RO_IDLE;   // Bank freed above
                  end
               end
            end
         endcase
      end
   end

   // Outgoing word from the read bank
   always_comb begin
      word_d.block_seq = rd_seq_q;
      word_d.slot      = rd_slot_q;
      word_d.last      = rd_slot_q == LAST_SLOT;
      word_d.vis       = bank_q[!fill_q][rd_slot_q];
   end

   always_ff @(posedge clk_x) begin
      if (send) begin
         rd_word_o <= word_d;
      end
   end

endmodule
